// ==== rtl/core_pkg.sv ====
package core_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  mem_size_t;

  // Access sizes, same coding as funct3[1:0]
  localparam mem_size_t size_byte = 2'd0;
  localparam mem_size_t size_half = 2'd1;
  localparam mem_size_t size_word = 2'd2;

  ////////////////////////////////////////////////////////////
  // Enums
  ////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt,
    alu_sltu, alu_xor, alu_srl, alu_sra,
    alu_or, alu_and, alu_eq, alu_ne,
    alu_lt, alu_ge, alu_ltu, alu_geu
  } alu_op_t;

  typedef enum logic [2:0] {
    st_wait,
    st_fetch,
    st_decode,
    st_exec,
    st_mem,
    st_write,
    st_illegal
  } ctrl_state_t;

  ////////////////////////////////////////////////////////////
  // RV32I major opcodes
  ////////////////////////////////////////////////////////////

  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_imm    = 7'b0010011;
  localparam logic [6:0] opc_reg    = 7'b0110011;

endpackage

// ==== rtl/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder (
  input  logic                clk,
  input  core_pkg::word_t     instr,
  output core_pkg::reg_idx_t  rd,
  output core_pkg::reg_idx_t  rs1,
  output core_pkg::reg_idx_t  rs2,
  output core_pkg::word_t     imm,
  output core_pkg::alu_op_t   alu_op,
  output logic                use_imm,
  output logic                is_lui,
  output logic                is_auipc,
  output logic                is_jal,
  output logic                is_jalr,
  output logic                is_branch,
  output logic                is_load,
  output logic                is_store,
  output logic                writes_rd,
  output logic                load_unsigned,
  output logic                invalid,
  output core_pkg::mem_size_t mem_size
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic fmt_r, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j;
  logic valid_d;
  core_pkg::word_t imm_d;
  core_pkg::alu_op_t arith_op;
  core_pkg::alu_op_t alu_op_d;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign fmt_r = (opcode == core_pkg::opc_reg);
  assign fmt_i = (opcode == core_pkg::opc_imm) || (opcode == core_pkg::opc_load) ||
                 (opcode == core_pkg::opc_jalr);
  assign fmt_s = (opcode == core_pkg::opc_store);
  assign fmt_b = (opcode == core_pkg::opc_branch);
  assign fmt_u = (opcode == core_pkg::opc_lui) || (opcode == core_pkg::opc_auipc);
  assign fmt_j = (opcode == core_pkg::opc_jal);

  always_comb begin
    imm_d = '0;
    if (fmt_i) begin
      imm_d = {{21{instr[31]}}, instr[30:20]};
    end else if (fmt_s) begin
      imm_d = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    end else if (fmt_b) begin
      imm_d = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    end else if (fmt_u) begin
      imm_d = {instr[31:12], 12'd0};
    end else if (fmt_j) begin
      imm_d = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    end
  end

  // Shared by register and immediate forms; SUB only exists as R-type
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (fmt_r && funct7[5]) ? core_pkg::alu_sub : core_pkg::alu_add;
      3'b001:  arith_op = core_pkg::alu_sll;
      3'b010:  arith_op = core_pkg::alu_slt;
      3'b011:  arith_op = core_pkg::alu_sltu;
      3'b100:  arith_op = core_pkg::alu_xor;
      3'b101:  arith_op = funct7[5] ? core_pkg::alu_sra : core_pkg::alu_srl;
      3'b110:  arith_op = core_pkg::alu_or;
      default: arith_op = core_pkg::alu_and;
    endcase
  end

  always_comb begin
    alu_op_d = core_pkg::alu_add;
    valid_d  = 1'b0;
    case (opcode)
      core_pkg::opc_lui, core_pkg::opc_auipc, core_pkg::opc_jal: valid_d = 1'b1;
      core_pkg::opc_jalr:  valid_d = (funct3 == 3'b000);
      core_pkg::opc_load:  valid_d = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
      core_pkg::opc_store: valid_d = !funct3[2] && (funct3[1:0] != 2'b11);
      core_pkg::opc_branch: begin
        valid_d = (funct3[2:1] != 2'b01);
        case (funct3)
          3'b000:  alu_op_d = core_pkg::alu_eq;
          3'b001:  alu_op_d = core_pkg::alu_ne;
          3'b100:  alu_op_d = core_pkg::alu_lt;
          3'b101:  alu_op_d = core_pkg::alu_ge;
          3'b110:  alu_op_d = core_pkg::alu_ltu;
          default: alu_op_d = core_pkg::alu_geu;
        endcase
      end
      core_pkg::opc_imm: begin
        alu_op_d = arith_op;
        if (funct3 == 3'b001) begin
          valid_d = (funct7 == 7'b0000000);
        end else if (funct3 == 3'b101) begin
          valid_d = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end else begin
          valid_d = 1'b1;
        end
      end
      core_pkg::opc_reg: begin
        alu_op_d = arith_op;
        valid_d  = (funct7 == 7'b0000000) ||
                   ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
      end
      default: valid_d = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    rd            <= (fmt_r || fmt_i || fmt_u || fmt_j) ? instr[11:7] : '0;
    rs1           <= (fmt_r || fmt_i || fmt_s || fmt_b) ? instr[19:15] : '0;
    rs2           <= (fmt_r || fmt_s || fmt_b) ? instr[24:20] : '0;
    imm           <= imm_d;
    alu_op        <= alu_op_d;
    use_imm       <= (opcode == core_pkg::opc_imm);
    is_lui        <= (opcode == core_pkg::opc_lui);
    is_auipc      <= (opcode == core_pkg::opc_auipc);
    is_jal        <= fmt_j;
    is_jalr       <= (opcode == core_pkg::opc_jalr);
    is_branch     <= fmt_b;
    is_load       <= (opcode == core_pkg::opc_load);
    is_store      <= fmt_s;
    writes_rd     <= fmt_r || fmt_i || fmt_u || fmt_j;
    load_unsigned <= funct3[2];
    mem_size      <= funct3[1:0];
    invalid       <= !valid_d;
  end

endmodule

// ==== rtl/int_reg_file.sv ====
`timescale 1ns/1ps

module int_reg_file #(
  parameter int NUM_REGS = 32
) (
  input  logic               clk,
  input  logic               rstn,
  input  core_pkg::reg_idx_t rs1_idx,
  input  core_pkg::reg_idx_t rs2_idx,
  input  core_pkg::reg_idx_t rd_idx,
  input  logic               rd_we,
  input  core_pkg::word_t    rd_data,
  output core_pkg::word_t    rs1_data,
  output core_pkg::word_t    rs2_data
);

  // x0 has no storage
  core_pkg::word_t regs [1:NUM_REGS-1];

  // Indices past NUM_REGS read as zero in the reduced build
  assign rs1_data = (rs1_idx == '0 || rs1_idx >= NUM_REGS) ? '0 : regs[rs1_idx];
  assign rs2_data = (rs2_idx == '0 || rs2_idx >= NUM_REGS) ? '0 : regs[rs2_idx];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && rd_idx != '0 && rd_idx < NUM_REGS) begin
      regs[rd_idx] <= rd_data;
    end
  end

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  logic              clk,
  input  logic              rstn,
  input  core_pkg::word_t   src1,
  input  core_pkg::word_t   src2,
  input  core_pkg::word_t   imm,
  input  logic              use_imm,
  input  core_pkg::alu_op_t op,
  output core_pkg::word_t   result
);

  core_pkg::word_t operand;
  core_pkg::word_t calc;
  logic [4:0] shamt;

  assign operand = use_imm ? imm : src2;
  assign shamt   = operand[4:0];

  always_comb begin
    case (op)
      core_pkg::alu_add:  calc = src1 + operand;
      core_pkg::alu_sub:  calc = src1 - operand;
      core_pkg::alu_sll:  calc = src1 << shamt;
      core_pkg::alu_slt:  calc = {31'd0, $signed(src1) < $signed(operand)};
      core_pkg::alu_sltu: calc = {31'd0, src1 < operand};
      core_pkg::alu_xor:  calc = src1 ^ operand;
      core_pkg::alu_srl:  calc = src1 >> shamt;
      core_pkg::alu_sra:  calc = $unsigned($signed(src1) >>> shamt);
      core_pkg::alu_or:   calc = src1 | operand;
      core_pkg::alu_and:  calc = src1 & operand;
      // Branch conditions yield 1 when taken
      core_pkg::alu_eq:   calc = {31'd0, src1 == operand};
      core_pkg::alu_ne:   calc = {31'd0, src1 != operand};
      core_pkg::alu_lt:   calc = {31'd0, $signed(src1) < $signed(operand)};
      core_pkg::alu_ge:   calc = {31'd0, $signed(src1) >= $signed(operand)};
      core_pkg::alu_ltu:  calc = {31'd0, src1 < operand};
      default:            calc = {31'd0, src1 >= operand};
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      result <= '0;
    end else begin
      result <= calc;
    end
  end

endmodule

// ==== rtl/lsu.sv ====
`timescale 1ns/1ps

module lsu (
  input  logic                clk,
  input  logic                rstn,
  input  logic                mem_start,
  input  logic                is_load,
  input  logic                is_store,
  input  logic                load_unsigned,
  input  core_pkg::mem_size_t mem_size,
  input  core_pkg::word_t     store_src,
  input  core_pkg::word_t     rdata,
  input  logic                mem_done,
  output core_pkg::word_t     wdata,
  output core_pkg::strb_t     data_we,
  output logic                load,
  output core_pkg::word_t     load_data
);

  core_pkg::strb_t strb;
  core_pkg::word_t load_fmt;
  logic sign_bit;

  always_comb begin
    case (mem_size)
      core_pkg::size_byte: strb = 4'b0001;
      core_pkg::size_half: strb = 4'b0011;
      default:             strb = 4'b1111;
    endcase
  end

  // Low bytes of the word only without a lane shift
  always_comb begin
    case (mem_size)
      core_pkg::size_byte: sign_bit = !load_unsigned && rdata[7];
      core_pkg::size_half: sign_bit = !load_unsigned && rdata[15];
      default:             sign_bit = 1'b0;
    endcase
    case (mem_size)
      core_pkg::size_byte: load_fmt = {{24{sign_bit}}, rdata[7:0]};
      core_pkg::size_half: load_fmt = {{16{sign_bit}}, rdata[15:0]};
      default:             load_fmt = rdata;
    endcase
  end

  // Strobes live for the first mem cycle only
  always_ff @(posedge clk) begin
    if (!rstn) begin
      data_we <= '0;
      load    <= 1'b0;
    end else begin
      data_we <= (mem_start && is_store) ? strb : '0;
      load    <= mem_start && is_load;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_start) begin
      wdata <= store_src;
    end
    if (mem_done && is_load) begin
      load_data <= load_fmt;
    end
  end

endmodule

// ==== rtl/core_control.sv ====
`timescale 1ns/1ps

module core_control #(
  parameter core_pkg::word_t RESET_PC = '0
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            invalid,
  input  logic            is_lui,
  input  logic            is_auipc,
  input  logic            is_jal,
  input  logic            is_jalr,
  input  logic            is_branch,
  input  logic            is_load,
  input  logic            is_store,
  input  logic            writes_rd,
  input  core_pkg::word_t imm,
  input  core_pkg::word_t rs1_data,
  input  core_pkg::word_t alu_result,
  input  core_pkg::word_t load_data,
  input  logic            mem_done,
  output core_pkg::word_t pc,
  output logic            mem_start,
  output logic            rd_we,
  output logic            illegal,
  output core_pkg::word_t wb_data
);

  core_pkg::ctrl_state_t state;
  core_pkg::ctrl_state_t state_next;
  core_pkg::word_t pc_plus4;
  core_pkg::word_t pc_plus_imm;
  core_pkg::word_t jalr_target;
  logic taken;

  assign pc_plus4    = pc + 32'd4;
  assign pc_plus_imm = pc + imm;
  assign jalr_target = (rs1_data + imm) & ~32'd1;
  // ALU compare result is still held during write
  assign taken       = is_branch && alu_result[0];

  ////////////////////////////////////////////////////////////
  // Phase sequencing
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      core_pkg::st_wait:   state_next = core_pkg::st_fetch;
      core_pkg::st_fetch:  state_next = core_pkg::st_decode;
      core_pkg::st_decode: state_next = invalid ? core_pkg::st_illegal : core_pkg::st_exec;
      core_pkg::st_exec: begin
        state_next = (is_load || is_store) ? core_pkg::st_mem : core_pkg::st_write;
      end
      core_pkg::st_mem: begin
        if (mem_done) begin
          state_next = core_pkg::st_write;
        end
      end
      core_pkg::st_write:  state_next = core_pkg::st_fetch;
      default:             state_next = core_pkg::st_illegal;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= core_pkg::st_wait;
    end else begin
      state <= state_next;
    end
  end

  assign mem_start = (state == core_pkg::st_exec) && (is_load || is_store);
  assign illegal   = (state == core_pkg::st_illegal);

  ////////////////////////////////////////////////////////////
  // Program counter and write-back
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      pc <= RESET_PC;
    end else if (state == core_pkg::st_write) begin
      if (is_jalr) begin
        pc <= jalr_target;
      end else if (is_jal || taken) begin
        pc <= pc_plus_imm;
      end else begin
        pc <= pc_plus4;
      end
    end
  end

  assign rd_we = (state == core_pkg::st_write) && writes_rd;

  always_comb begin
    if (is_lui) begin
      wb_data = imm;
    end else if (is_auipc) begin
      wb_data = pc_plus_imm;
    end else if (is_jal || is_jalr) begin
      wb_data = pc_plus4;
    end else if (is_load) begin
      wb_data = load_data;
    end else begin
      wb_data = alu_result;
    end
  end

endmodule

// ==== rtl/core_top.sv ====
`timescale 1ns/1ps

module core_top #(
  parameter core_pkg::word_t RESET_PC = '0,
  parameter int              NUM_REGS = 32
) (
  input  logic            clk,
  input  logic            rstn,
  input  core_pkg::word_t instr,
  output core_pkg::word_t pc,
  output core_pkg::word_t data_addr,
  output core_pkg::word_t wdata,
  output core_pkg::strb_t data_we,
  output logic            load,
  input  core_pkg::word_t rdata,
  input  logic            mem_done,
  output logic            illegal
);

  core_pkg::reg_idx_t rd, rs1, rs2;
  core_pkg::word_t imm, rs1_data, rs2_data, alu_result, load_data, wb_data;
  core_pkg::alu_op_t alu_op;
  core_pkg::mem_size_t mem_size;
  logic use_imm, is_lui, is_auipc, is_jal, is_jalr, is_branch;
  logic is_load, is_store, writes_rd, load_unsigned, invalid;
  logic mem_start, rd_we;

  assign data_addr = rs1_data + imm;

  rv_decoder u_decoder (
    .clk(clk), .instr(instr), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm), .alu_op(alu_op),
    .use_imm(use_imm), .is_lui(is_lui), .is_auipc(is_auipc), .is_jal(is_jal),
    .is_jalr(is_jalr), .is_branch(is_branch), .is_load(is_load), .is_store(is_store),
    .writes_rd(writes_rd), .load_unsigned(load_unsigned), .invalid(invalid),
    .mem_size(mem_size)
  );

  int_reg_file #(.NUM_REGS(NUM_REGS)) u_regs (
    .clk(clk), .rstn(rstn), .rs1_idx(rs1), .rs2_idx(rs2), .rd_idx(rd), .rd_we(rd_we),
    .rd_data(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  alu u_alu (
    .clk(clk), .rstn(rstn), .src1(rs1_data), .src2(rs2_data), .imm(imm),
    .use_imm(use_imm), .op(alu_op), .result(alu_result)
  );

  lsu u_lsu (
    .clk(clk), .rstn(rstn), .mem_start(mem_start), .is_load(is_load), .is_store(is_store),
    .load_unsigned(load_unsigned), .mem_size(mem_size), .store_src(rs2_data),
    .rdata(rdata), .mem_done(mem_done), .wdata(wdata), .data_we(data_we), .load(load),
    .load_data(load_data)
  );

  core_control #(.RESET_PC(RESET_PC)) u_control (
    .clk(clk), .rstn(rstn), .invalid(invalid), .is_lui(is_lui), .is_auipc(is_auipc),
    .is_jal(is_jal), .is_jalr(is_jalr), .is_branch(is_branch), .is_load(is_load),
    .is_store(is_store), .writes_rd(writes_rd), .imm(imm), .rs1_data(rs1_data),
    .alu_result(alu_result), .load_data(load_data), .mem_done(mem_done), .pc(pc),
    .mem_start(mem_start), .rd_we(rd_we), .illegal(illegal), .wb_data(wb_data)
  );

endmodule

// ==== tb/tb_core_assert.sv ====
`timescale 1ns/1ps

module tb_core_assert (
  input logic            clk,
  input logic            rstn,
  input logic [2:0]      state,
  input core_pkg::word_t pc,
  input core_pkg::strb_t data_we,
  input logic            load,
  input logic            rd_we,
  input logic            illegal
);

  a_store_or_load: assert property (@(posedge clk) disable iff (!rstn)
    !(data_we != 4'd0 && load))
    else $error("data_we and load active in the same cycle");

  a_pc_aligned: assert property (@(posedge clk) disable iff (!rstn) pc[1:0] == 2'b00)
    else $error("pc not word-aligned");

  // Write is entered only from exec or mem
  a_write_phase: assert property (@(posedge clk) disable iff (!rstn)
    rd_we |-> state == core_pkg::st_write &&
              ($past(state) == core_pkg::st_exec || $past(state) == core_pkg::st_mem))
    else $error("register write outside a write state entered from exec or mem");

  // Held until reset
  a_illegal_sticky: assert property (@(posedge clk) disable iff (!rstn) illegal |=> illegal)
    else $error("illegal dropped without reset");

endmodule

bind core_top tb_core_assert u_core_assert (
  .clk(clk), .rstn(rstn), .state(u_control.state), .pc(pc), .data_we(data_we),
  .load(load), .rd_we(u_control.rd_we), .illegal(illegal)
);

// ==== tb/tb_core.sv ====
`timescale 1ns/1ps

module tb_core;

  localparam int CLK_PERIOD = 40;
  localparam core_pkg::word_t RES_ADDR = 32'h100;

  // Row operations with register forms ahead of immediate forms
  localparam int OP_ADD = 0, OP_SUB = 1, OP_SLL = 2, OP_SLT = 3, OP_SLTU = 4;
  localparam int OP_XOR = 5, OP_SRL = 6, OP_SRA = 7, OP_OR = 8, OP_AND = 9;
  localparam int OP_ADDI = 10, OP_SLTI = 11, OP_SLTIU = 12, OP_XORI = 13, OP_ORI = 14;
  localparam int OP_ANDI = 15, OP_SLLI = 16, OP_SRLI = 17, OP_SRAI = 18;
  localparam int OP_LUI = 19, OP_AUIPC = 20;
  localparam int OP_BEQ = 21, OP_BNE = 22, OP_BLT = 23, OP_BGE = 24, OP_BLTU = 25;
  localparam int OP_BGEU = 26, OP_JAL = 27, OP_JALR = 28;
  localparam int OP_SB = 29, OP_SH = 30, OP_LB = 31, OP_LH = 32, OP_LW = 33;
  localparam int OP_LBU = 34, OP_LHU = 35, OP_X0 = 36;

  typedef struct {
    int              op;
    core_pkg::word_t a;
    core_pkg::word_t b;
    core_pkg::word_t exp;
  } row_t;

  logic            clk;
  logic            rstn;
  core_pkg::word_t instr;
  core_pkg::word_t pc;
  core_pkg::word_t data_addr;
  core_pkg::word_t wdata;
  core_pkg::word_t rdata;
  core_pkg::strb_t data_we;
  logic            load;
  logic            mem_done;
  logic            illegal;

  core_pkg::word_t rom [0:63];
  core_pkg::word_t dmem [0:255];
  logic [5:0]      wr_ptr;
  logic [7:0]      hold_idx;
  int              cnt;
  row_t            rows [$];
  logic            rows_ready;

  assign instr = rom[pc[7:2]];

  core_top #(.RESET_PC(32'd0), .NUM_REGS(32)) UUT (
    .clk(clk), .rstn(rstn), .instr(instr), .pc(pc), .data_addr(data_addr),
    .wdata(wdata), .data_we(data_we), .load(load), .rdata(rdata),
    .mem_done(mem_done), .illegal(illegal)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Data memory with random answer delay
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rstn) begin
      cnt      <= 0;
      mem_done <= 1'b0;
    end else begin
      mem_done <= 1'b0;
      if (cnt == 1) begin
        mem_done <= 1'b1;
        rdata    <= dmem[hold_idx];
      end
      if (cnt != 0) begin
        cnt <= cnt - 1;
      end
      if (data_we != 4'd0 || load) begin
        for (int i = 0; i < 4; i++) begin
          if (data_we[i]) begin
            dmem[data_addr[9:2]][8*i +: 8] <= wdata[8*i +: 8];
          end
        end
        cnt      <= $urandom_range(5, 2) - 1;
        hold_idx <= data_addr[9:2];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Instruction encoders
  ////////////////////////////////////////////////////////////

  function automatic core_pkg::word_t enc_r(logic [6:0] f7, logic [2:0] f3,
                                            logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, core_pkg::opc_reg};
  endfunction

  function automatic core_pkg::word_t enc_i(logic [6:0] opc, logic [2:0] f3,
                                            logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic core_pkg::word_t enc_s(logic [2:0] f3, logic [4:0] base,
                                            logic [4:0] src, logic [11:0] imm);
    return {imm[11:5], src, base, f3, imm[4:0], core_pkg::opc_store};
  endfunction

  function automatic core_pkg::word_t enc_b(logic [2:0] f3, logic [4:0] rs1,
                                            logic [4:0] rs2, logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], core_pkg::opc_branch};
  endfunction

  function automatic core_pkg::word_t enc_u(logic [6:0] opc, logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic core_pkg::word_t enc_j(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, core_pkg::opc_jal};
  endfunction

  ////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////

  function automatic int base_op(int op);
    case (op)
      OP_ADDI:  return OP_ADD;
      OP_SLTI:  return OP_SLT;
      OP_SLTIU: return OP_SLTU;
      OP_XORI:  return OP_XOR;
      OP_ORI:   return OP_OR;
      OP_ANDI:  return OP_AND;
      OP_SLLI:  return OP_SLL;
      OP_SRLI:  return OP_SRL;
      OP_SRAI:  return OP_SRA;
      default:  return op;
    endcase
  endfunction

  function automatic logic [2:0] alu_funct3(int op);
    case (base_op(op))
      OP_ADD, OP_SUB: return 3'd0;
      OP_SLL:         return 3'd1;
      OP_SLT:         return 3'd2;
      OP_SLTU:        return 3'd3;
      OP_XOR:         return 3'd4;
      OP_SRL, OP_SRA: return 3'd5;
      OP_OR:          return 3'd6;
      default:        return 3'd7;
    endcase
  endfunction

  // Two's complement order from the sign bits, then the magnitude
  function automatic logic signed_less(core_pkg::word_t a, core_pkg::word_t b);
    if (a[31] != b[31]) return a[31];
    return a < b;
  endfunction

  function automatic core_pkg::word_t shift_right_arith(core_pkg::word_t a, logic [4:0] s);
    core_pkg::word_t fill;
    fill = a[31] ? ~(32'hFFFFFFFF >> s) : 32'd0;
    return (a >> s) | fill;
  endfunction

  function automatic core_pkg::word_t ref_alu(int op, core_pkg::word_t a, core_pkg::word_t b);
    case (base_op(op))
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_SLL:  return a << b[4:0];
      OP_SLT:  return signed_less(a, b) ? 32'd1 : 32'd0;
      OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
      OP_XOR:  return a ^ b;
      OP_SRL:  return a >> b[4:0];
      OP_SRA:  return shift_right_arith(a, b[4:0]);
      OP_OR:   return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(int op, core_pkg::word_t a, core_pkg::word_t b);
    case (op)
      OP_BEQ:  return a == b;
      OP_BNE:  return a != b;
      OP_BLT:  return signed_less(a, b);
      OP_BGE:  return !signed_less(a, b);
      OP_BLTU: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // Program layout puts the operation at 16, so the link value is 20
  function automatic core_pkg::word_t expected_value(int op, core_pkg::word_t a,
                                                     core_pkg::word_t b);
    core_pkg::word_t imm_i;
    imm_i = {{20{b[11]}}, b[11:0]};
    if (op <= OP_AND) return ref_alu(op, a, b);
    if (op <= OP_SRAI) return ref_alu(op, a, imm_i);
    if (op >= OP_BEQ && op <= OP_BGEU) return branch_taken(op, a, b) ? 32'd1 : 32'd2;
    case (op)
      OP_LUI:          return {a[19:0], 12'd0};
      OP_AUIPC:        return 32'd16 + {a[19:0], 12'd0};
      OP_JAL, OP_JALR: return 32'd20;
      OP_SB:           return {a[31:8], b[7:0]};
      OP_SH:           return {a[31:16], b[15:0]};
      OP_LB:           return {{24{a[7]}}, a[7:0]};
      OP_LH:           return {{16{a[15]}}, a[15:0]};
      OP_LBU:          return {24'd0, a[7:0]};
      OP_LHU:          return {16'd0, a[15:0]};
      OP_LW:           return a;
      default:         return 32'd0;
    endcase
  endfunction

  function automatic int store_count(int op);
    if (op == OP_SB || op == OP_SH) return 3;
    if (op >= OP_LB && op <= OP_LHU) return 2;
    return 1;
  endfunction

  ////////////////////////////////////////////////////////////
  // Checking and program building
  ////////////////////////////////////////////////////////////

  task automatic check(input string name, input core_pkg::word_t got,
                       input core_pkg::word_t exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("Checks failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "run stopped");
  endtask

  task automatic emit(input core_pkg::word_t w);
    rom[wr_ptr] = w;
    wr_ptr = wr_ptr + 6'd1;
  endtask

  task automatic clear_rom;
    // Self loop on x0 everywhere
    for (int i = 0; i < 64; i++) begin
      rom[i[5:0]] = 32'h0000006f;
    end
    wr_ptr = 6'd0;
  endtask

  task automatic load_const(input logic [4:0] rd, input core_pkg::word_t val);
    core_pkg::word_t hi;
    hi = val + 32'h800;
    emit(enc_u(core_pkg::opc_lui, rd, hi[31:12]));
    emit(enc_i(core_pkg::opc_imm, 3'd0, rd, rd, val[11:0]));
  endtask

  task automatic build_program(input row_t r);
    logic [11:0] imm12;
    logic [2:0] f3;
    clear_rom();
    load_const(5'd1, r.a);
    load_const(5'd2, r.b);
    if (r.op <= OP_AND) begin
      emit(enc_r((r.op == OP_SUB || r.op == OP_SRA) ? 7'h20 : 7'h00,
                 alu_funct3(r.op), 5'd3, 5'd1, 5'd2));
    end else if (r.op <= OP_SRAI) begin
      imm12 = r.b[11:0];
      if (r.op == OP_SLLI || r.op == OP_SRLI) imm12 = {7'h00, r.b[4:0]};
      if (r.op == OP_SRAI) imm12 = {7'h20, r.b[4:0]};
      emit(enc_i(core_pkg::opc_imm, alu_funct3(r.op), 5'd3, 5'd1, imm12));
    end else if (r.op == OP_LUI || r.op == OP_AUIPC) begin
      emit(enc_u((r.op == OP_LUI) ? core_pkg::opc_lui : core_pkg::opc_auipc, 5'd3, r.a[19:0]));
    end else if (r.op <= OP_BGEU) begin
      case (r.op)
        OP_BEQ:  f3 = 3'd0;
        OP_BNE:  f3 = 3'd1;
        OP_BLT:  f3 = 3'd4;
        OP_BGE:  f3 = 3'd5;
        OP_BLTU: f3 = 3'd6;
        default: f3 = 3'd7;
      endcase
      emit(enc_b(f3, 5'd1, 5'd2, 13'd12));
      emit(enc_i(core_pkg::opc_imm, 3'd0, 5'd3, 5'd0, 12'd2));
      emit(enc_j(5'd0, 21'd8));
      emit(enc_i(core_pkg::opc_imm, 3'd0, 5'd3, 5'd0, 12'd1));
    end else if (r.op == OP_JAL || r.op == OP_JALR) begin
      if (r.op == OP_JAL) emit(enc_j(5'd3, 21'd8));
      else emit(enc_i(core_pkg::opc_jalr, 3'd0, 5'd3, 5'd1, 12'd0));
      emit(enc_i(core_pkg::opc_imm, 3'd0, 5'd3, 5'd0, 12'h7ff));
    end else if (r.op == OP_SB || r.op == OP_SH) begin
      emit(enc_s(3'd2, 5'd0, 5'd1, 12'h080));
      emit(enc_s((r.op == OP_SB) ? 3'd0 : 3'd1, 5'd0, 5'd2, 12'h080));
      emit(enc_i(core_pkg::opc_load, 3'd2, 5'd3, 5'd0, 12'h080));
    end else if (r.op <= OP_LHU) begin
      case (r.op)
        OP_LB:   f3 = 3'd0;
        OP_LH:   f3 = 3'd1;
        OP_LW:   f3 = 3'd2;
        OP_LBU:  f3 = 3'd4;
        default: f3 = 3'd5;
      endcase
      emit(enc_s(3'd2, 5'd0, 5'd1, 12'h080));
      emit(enc_i(core_pkg::opc_load, f3, 5'd3, 5'd0, 12'h080));
    end else begin
      emit(enc_r(7'h00, 3'd0, 5'd0, 5'd1, 5'd2));
    end
    emit(enc_s(3'd2, 5'd0, (r.op == OP_X0) ? 5'd0 : 5'd3, RES_ADDR[11:0]));
  endtask

  task automatic add_row(input int op, input core_pkg::word_t a, input core_pkg::word_t b,
                         input logic ra, input logic rb);
    row_t r;
    r.op = op;
    r.a = ra ? $urandom() : a;
    r.b = rb ? $urandom() : b;
    r.exp = expected_value(op, r.a, r.b);
    rows.push_back(r);
  endtask

  task automatic start_reset;
    @(posedge clk);
    rstn <= 1'b0;
  endtask

  task automatic finish_reset;
    repeat (5) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    check("pc", pc, 32'd0);
    check("data_we", {28'd0, data_we}, 32'd0);
    check("load", {31'd0, load}, 32'd0);
    check("illegal", {31'd0, illegal}, 32'd0);
  endtask

  task automatic wait_stores(input int n);
    int seen;
    int waited;
    seen = 0;
    waited = 0;
    while (seen < n) begin
      @(negedge clk);
      if (data_we != 4'd0) seen++;
      waited++;
      if (waited > 400) abort_run("the core issued no store within 400 cycles");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus table and main sequence
  ////////////////////////////////////////////////////////////

  task automatic build_table;
    add_row(OP_ADD, 0, 0, 1, 1);
    add_row(OP_SUB, 0, 0, 1, 1);
    add_row(OP_SLL, 0, 32'd35, 1, 0);
    add_row(OP_SLT, 32'hFFFFFFF0, 32'd5, 0, 0);
    add_row(OP_SLTU, 32'hFFFFFFF0, 32'd5, 0, 0);
    add_row(OP_XOR, 0, 0, 1, 1);
    add_row(OP_SRL, 32'h80000000, 32'd31, 0, 0);
    add_row(OP_SRA, 32'h80000010, 32'd4, 0, 0);
    add_row(OP_SRA, 0, 0, 1, 1);
    add_row(OP_OR, 0, 0, 1, 1);
    add_row(OP_AND, 0, 0, 1, 1);
    add_row(OP_ADDI, 0, 0, 1, 1);
    add_row(OP_SLTI, 32'hFFFFFFFF, 32'd1, 0, 0);
    add_row(OP_SLTIU, 32'd3, 32'hFFF, 0, 0);
    add_row(OP_XORI, 0, 0, 1, 1);
    add_row(OP_ORI, 0, 0, 1, 1);
    add_row(OP_ANDI, 0, 0, 1, 1);
    add_row(OP_SLLI, 0, 32'd7, 1, 0);
    add_row(OP_SRLI, 32'hF0000000, 32'd28, 0, 0);
    add_row(OP_SRAI, 32'hF0000000, 32'd28, 0, 0);
    add_row(OP_LUI, 32'hABCDE, 0, 0, 0);
    add_row(OP_AUIPC, 32'h00012, 0, 0, 0);
    for (int op = OP_BEQ; op <= OP_BGEU; op++) begin
      add_row(op, 32'd5, 32'd5, 0, 0);
      add_row(op, 32'hFFFFFFFF, 32'd1, 0, 0);
      add_row(op, 32'd1, 32'hFFFFFFFF, 0, 0);
    end
    add_row(OP_JAL, 0, 0, 0, 0);
    add_row(OP_JALR, 32'd24, 0, 0, 0);
    add_row(OP_SB, 32'h11223344, 32'hAABBCCDD, 0, 0);
    add_row(OP_SH, 32'h11223344, 32'hAABBCCDD, 0, 0);
    add_row(OP_LB, 32'h12345680, 0, 0, 0);
    add_row(OP_LH, 32'h00008001, 0, 0, 0);
    add_row(OP_LBU, 32'hFFFFFFF0, 0, 0, 0);
    add_row(OP_LHU, 32'hFFFFF00F, 0, 0, 0);
    add_row(OP_LW, 0, 0, 1, 0);
    add_row(OP_X0, 0, 0, 1, 1);
  endtask

  initial begin
    rstn = 1'b0;
    rdata = '0;
    mem_done = 1'b0;
    cnt = 0;
    hold_idx = '0;
    rows_ready = 1'b0;
    void'($urandom(78941));
    clear_rom();
    for (int i = 0; i < 256; i++) begin
      dmem[i[7:0]] = 32'hC0DE0000 ^ (i * 4);
    end
    build_table();
    rows_ready = 1'b1;

    foreach (rows[i]) begin
      start_reset();
      build_program(rows[i]);
      finish_reset();
      wait_stores(store_count(rows[i].op));
      check("data_addr", data_addr, RES_ADDR);
      check("data_we", {28'd0, data_we}, 32'hF);
      check("wdata", wdata, rows[i].exp);
    end

    // Invalid word between two valid instructions
    start_reset();
    clear_rom();
    emit(enc_i(core_pkg::opc_imm, 3'd0, 5'd1, 5'd0, 12'd5));
    emit(32'hFFFFFFFF);
    emit(enc_s(3'd2, 5'd0, 5'd1, RES_ADDR[11:0]));
    finish_reset();
    for (int n = 0; !illegal; n++) begin
      if (n > 50) abort_run("illegal was not raised for an invalid instruction");
      @(negedge clk);
    end
    repeat (40) begin
      @(negedge clk);
      check("data_we", {28'd0, data_we}, 32'd0);
      check("illegal", {31'd0, illegal}, 32'd1);
    end

    $display("All checks passed");
    $finish;
  end

  initial begin
    wait (rows_ready);
    #((rows.size() + 4) * 80 * CLK_PERIOD);
    abort_run("watchdog expired before the test sequence finished");
  end

endmodule

// ==== all.f ====
rtl/core_pkg.sv
rtl/rv_decoder.sv
rtl/int_reg_file.sv
rtl/alu.sv
rtl/lsu.sv
rtl/core_control.sv
rtl/core_top.sv
tb/tb_core_assert.sv
tb/tb_core.sv

// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module tb_core -f all.f

sim:
	verilator --binary --timing --assert --top-module tb_core -f all.f -o sim_core
	./obj_dir/sim_core > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Checks failed" sim.log; then \
	  echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "All checks passed" sim.log; then \
	  echo "simulation ended without the pass message"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
